// File: csr_unit.f
+incdir+bench
src/csr_pkg.sv
src/csr_access_decode.sv
src/csr_state_regs.sv
src/csr_timer.sv
src/csr_read_result.sv
src/csr_unit.sv
bench/csr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/csr_unit_sim

if ! verilator --binary --timing --top-module csr_unit_tb -f csr_unit.f -o csr_unit_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$BIN" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "^tests failed$" "$LOG"; then
    exit 1
fi

exit 0

// File: bench/csr_unit_tests.svh
localparam csr_addr_t KEPT_ADDRS [15] = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA,
    CSR_BADV, CSR_EENTRY, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID,
    CSR_TCFG, CSR_TVAL, CSR_TICLR};

function automatic logic [31:0] write_mask(input csr_addr_t addr);
    case (addr)
        CSR_CRMD:   return 32'h0000_01ff;
        CSR_PRMD:   return 32'h0000_0007;
        CSR_ECFG:   return 32'h0000_1bff;
        CSR_ESTAT:  return 32'h0000_0003;
        CSR_EENTRY: return 32'hffff_ffc0;
        default:    return 32'hffff_ffff;
    endcase
endfunction

function automatic logic [31:0] reset_value(input csr_addr_t addr);
    if (addr == CSR_CRMD) return 32'h0000_0008; // Direct address mode
    if (addr == CSR_TID) return TID_VALUE;
    return 32'h0;
endfunction

task automatic verify_reset_state();
    logic [31:0] r;
    compare_word("ack_o after reset", 32'(ack_o), 32'h0);
    compare_word("int_pending_o after reset", 32'(int_pending_o), 32'h0);
    for (int k = 0; k < 15; k++) begin
        csr_access(1'b0, KEPT_ADDRS[k], 32'h0, r);
        compare_word($sformatf("reset CSR %h", KEPT_ADDRS[k]), r, reset_value(KEPT_ADDRS[k]));
    end
endtask

// Timer registers stay out so the TI bit keeps still
task automatic exchange_and_masks();
    logic [31:0] r;
    logic [31:0] w1;
    logic [31:0] w2;
    csr_addr_t   a;
    for (int k = 0; k < 12; k++) begin
        a  = KEPT_ADDRS[k];
        w1 = $urandom;
        w2 = $urandom;
        csr_access(1'b1, a, w1, r);
        compare_word($sformatf("old value of CSR %h", a), r, reset_value(a));
        csr_access(1'b1, a, w2, r);
        compare_word($sformatf("first write to CSR %h", a), r, w1 & write_mask(a));
        csr_access(1'b0, a, 32'h0, r);
        compare_word($sformatf("second write to CSR %h", a), r, w2 & write_mask(a));
        if (a == CSR_EENTRY) begin
            compare_word("eentry_o after write", eentry_o, w2 & write_mask(a));
        end
    end
    w1 = $urandom;
    csr_access(1'b1, CSR_SAVE0, w1, r);
    csr_access(1'b1, 14'h0100, $urandom, r); // Unmapped number
    compare_word("unknown CSR on write", r, 32'h0);
    csr_access(1'b0, 14'h0100, 32'h0, r);
    compare_word("unknown CSR on read", r, 32'h0);
    csr_access(1'b0, CSR_SAVE0, 32'h0, r);
    compare_word("SAVE0 after unknown write", r, w1);
endtask

task automatic exception_entry();
    logic [31:0]           r;
    logic [31:0]           pc;
    logic [31:0]           badaddr;
    logic [ECODE_W-1:0]    code;
    logic [ESUBCODE_W-1:0] sub;
    for (int k = 0; k < 2; k++) begin
        code    = (k == 0) ? ECODE_ALE : ECODE_ADE;
        pc      = $urandom & 32'hffff_fffc;
        badaddr = $urandom;
        sub     = 9'($urandom);
        csr_access(1'b1, CSR_CRMD, 32'h0000_000f, r); // PLV3 with IE on
        exc_valid_i    = 1'b1;
        exc_ecode_i    = code;
        exc_esubcode_i = sub;
        exc_pc_i       = pc;
        exc_addr_i     = badaddr;
        @(posedge clk);
        #1;
        exc_valid_i = 1'b0;
        compare_word("plv_o after exception", 32'(plv_o), 32'h0);
        compare_word("ie_o after exception", 32'(ie_o), 32'h0);
        compare_word("era_o after exception", era_o, pc);
        csr_access(1'b0, CSR_PRMD, 32'h0, r);
        compare_word("PRMD saved PLV and IE", r, 32'h0000_0007);
        csr_access(1'b0, CSR_CRMD, 32'h0, r);
        compare_word("CRMD after exception", r, 32'h0000_0008);
        csr_access(1'b0, CSR_ESTAT, 32'h0, r);
        compare_word("ESTAT Ecode", 32'(r[21:16]), 32'(code));
        compare_word("ESTAT EsubCode", 32'(r[30:22]), 32'(sub));
        csr_access(1'b0, CSR_BADV, 32'h0, r);
        compare_word("BADV after exception", r, (k == 0) ? badaddr : pc);
    end
endtask

task automatic ertn_return();
    logic [31:0] r;
    logic [2:0]  p;
    for (int k = 0; k < 2; k++) begin
        p = (k == 0) ? 3'b111 : 3'($urandom);
        csr_access(1'b1, CSR_PRMD, 32'(p), r);
        csr_access(1'b1, CSR_CRMD, 32'h0000_0008, r);
        ertn_i = 1'b1;
        @(posedge clk);
        #1;
        ertn_i = 1'b0;
        compare_word("plv_o after ertn", 32'(plv_o), 32'(p[1:0]));
        compare_word("ie_o after ertn", 32'(ie_o), 32'(p[2]));
    end
endtask

task automatic interrupt_status();
    logic [31:0] r;
    logic [31:0] ecfg;
    logic [12:0] lines;
    logic        ie;
    logic        expected;
    csr_access(1'b1, CSR_ESTAT, 32'h0, r); // Software bits off
    hwi_i = 8'($urandom);
    ipi_i = 1'($urandom);
    @(posedge clk);
    #1;
    lines = {ipi_i, 2'b00, hwi_i, 2'b00};
    csr_access(1'b0, CSR_ESTAT, 32'h0, r);
    compare_word("ESTAT interrupt bits", 32'(r[12:0]), 32'(lines));
    for (int k = 0; k < 8; k++) begin
        ecfg = (k < 2) ? 32'hffff_ffff : $urandom;
        ie   = k[0];
        csr_access(1'b1, CSR_ECFG, ecfg, r);
        csr_access(1'b1, CSR_CRMD, {28'h0, 1'b1, ie, 2'b00}, r);
        expected = ie && |(lines & ecfg[12:0] & 13'h1bff);
        compare_word("int_pending_o", 32'(int_pending_o), 32'(expected));
    end
    hwi_i = '0;
    ipi_i = 1'b0;
endtask

task automatic timer_countdown();
    logic [31:0] r;
    int          n;
    n = 5 + int'($urandom % 32'd8);
    csr_access(1'b1, CSR_TCFG, (32'(n) << 2) | 32'h1, r); // One-shot
    repeat (4 * n + 8) @(posedge clk);
    #1;
    csr_access(1'b0, CSR_TVAL, 32'h0, r);
    compare_word("TVAL after one-shot count", r, 32'h0);
    csr_access(1'b0, CSR_ESTAT, 32'h0, r);
    compare_word("ESTAT TI after count", 32'(r[11]), 32'h1);
    csr_access(1'b1, CSR_TICLR, 32'h1, r);
    compare_word("TICLR read", r, 32'h0);
    csr_access(1'b0, CSR_ESTAT, 32'h0, r);
    compare_word("ESTAT TI after clear", 32'(r[11]), 32'h0);
    csr_access(1'b1, CSR_TCFG, (32'(n) << 2) | 32'h3, r); // Periodic
    repeat (4 * n + 2) @(posedge clk);
    #1;
    csr_access(1'b0, CSR_TVAL, 32'h0, r);
    checks++;
    if (r == 32'h0) begin
        errors++;
        $display("Mismatch at %0t ns: TVAL did not reload in periodic mode", $time);
    end
    csr_access(1'b1, CSR_TCFG, 32'h0, r);
endtask

// File: bench/csr_unit_tb.sv
`timescale 1ns/100ps

module csr_unit_tb;
    import csr_pkg::*;

    localparam logic [31:0] TID_VALUE = 32'h0000_1a2b;
    localparam int RESET_CYCLES    = 16;
    localparam int ACCESS_COUNT    = 100;              // 95 accesses over all tests
    localparam int TIMER_CYCLES    = 2 * (4 * 12 + 8); // Both timer waits at the largest InitVal
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * ACCESS_COUNT + TIMER_CYCLES;
    localparam int ACK_LIMIT       = 20;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  req_i;
    logic                  we_i;
    csr_addr_t             addr_i;
    logic [31:0]           wdata_i;
    logic                  exc_valid_i;
    logic [ECODE_W-1:0]    exc_ecode_i;
    logic [ESUBCODE_W-1:0] exc_esubcode_i;
    logic [31:0]           exc_pc_i;
    logic [31:0]           exc_addr_i;
    logic                  ertn_i;
    logic [HWI_W-1:0]      hwi_i;
    logic                  ipi_i;
    logic                  ack_o;
    logic [31:0]           rdata_o;
    logic [1:0]            plv_o;
    logic                  ie_o;
    logic [31:0]           eentry_o;
    logic [31:0]           era_o;
    logic                  int_pending_o;

    int errors = 0;
    int checks = 0;

    always #2 clk = ~clk; // 4 ns period

    csr_unit #(.TID_RESET(TID_VALUE)) i_dut (.*);

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s read %h, expected %h", $time, what, got, expected);
        end
    endtask

    // Four-phase exchange, entered and left 1 ns after a rising edge
    task automatic csr_access(input logic we, input csr_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        req_i   = 1'b1;
        we_i    = we;
        addr_i  = addr;
        wdata_i = wdata;
        @(posedge clk);
        #1;
        while (!ack_o && waited < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!ack_o) begin
            errors++;
            $display("No acknowledge from the DUT at %0t ns for CSR %h", $time, addr);
        end
        rdata = rdata_o;
        req_i = 1'b0;
        waited = 0;
        @(posedge clk);
        #1;
        while (ack_o && waited < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (ack_o) begin
            errors++;
            $display("ack_o stayed high after req_i dropped at %0t ns", $time);
        end
    endtask

    `include "csr_unit_tests.svh"

    initial begin
        #(4 * WATCHDOG_CYCLES);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hff87_ce81));
        rst            = 1'b1;
        req_i          = 1'b0;
        we_i           = 1'b0;
        addr_i         = '0;
        wdata_i        = '0;
        exc_valid_i    = 1'b0;
        exc_ecode_i    = '0;
        exc_esubcode_i = '0;
        exc_pc_i       = '0;
        exc_addr_i     = '0;
        ertn_i         = 1'b0;
        hwi_i          = '0;
        ipi_i          = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        verify_reset_state();
        exchange_and_masks();
        exception_entry();
        ertn_return();
        interrupt_status();
        timer_countdown();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: src/csr_unit.sv
`timescale 1ns/100ps

module csr_unit #(
    parameter logic [31:0] TID_RESET = 32'h0000_0000
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_i,
    input  logic                            we_i,
    input  csr_pkg::csr_addr_t              addr_i,
    input  logic [31:0]                     wdata_i,
    input  logic                            exc_valid_i,
    input  logic [csr_pkg::ECODE_W-1:0]     exc_ecode_i,
    input  logic [csr_pkg::ESUBCODE_W-1:0]  exc_esubcode_i,
    input  logic [31:0]                     exc_pc_i,
    input  logic [31:0]                     exc_addr_i,
    input  logic                            ertn_i,
    input  logic [csr_pkg::HWI_W-1:0]       hwi_i,
    input  logic                            ipi_i,
    output logic                            ack_o,
    output logic [31:0]                     rdata_o,
    output logic [1:0]                      plv_o,
    output logic                            ie_o,
    output logic [31:0]                     eentry_o,
    output logic [31:0]                     era_o,
    output logic                            int_pending_o
);
    import csr_pkg::*;

    logic        acc_go;
    logic        acc_we;
    csr_idx_e    acc_idx;
    logic [31:0] acc_wdata;
    logic        timer_int;

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] ecfg;
    logic [31:0] estat;
    logic [31:0] badv;
    logic [31:0] save0;
    logic [31:0] save1;
    logic [31:0] save2;
    logic [31:0] save3;
    logic [31:0] tid;
    logic [31:0] tcfg;
    logic [31:0] tval;
    logic [31:0] ticlr;

    csr_access_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .ack_o       (ack_o),
        .acc_go_o    (acc_go),
        .acc_we_o    (acc_we),
        .acc_idx_o   (acc_idx),
        .acc_wdata_o (acc_wdata)
    );

    csr_state_regs #(
        .TID_RESET (TID_RESET)
    ) u_state (
        .clk (clk), .rst (rst),
        .acc_go_i (acc_go), .acc_we_i (acc_we),
        .acc_idx_i (acc_idx), .acc_wdata_i (acc_wdata),
        .exc_valid_i (exc_valid_i), .exc_ecode_i (exc_ecode_i),
        .exc_esubcode_i (exc_esubcode_i), .exc_pc_i (exc_pc_i),
        .exc_addr_i (exc_addr_i), .ertn_i (ertn_i),
        .hwi_i (hwi_i), .ipi_i (ipi_i), .timer_int_i (timer_int),
        .crmd_o (crmd), .prmd_o (prmd), .ecfg_o (ecfg), .estat_o (estat),
        .era_o (era_o), .badv_o (badv), .eentry_o (eentry_o),
        .save0_o (save0), .save1_o (save1), .save2_o (save2), .save3_o (save3),
        .tid_o (tid), .plv_o (plv_o), .ie_o (ie_o), .int_pending_o (int_pending_o)
    );

    csr_timer u_timer (
        .clk (clk), .rst (rst),
        .acc_go_i (acc_go), .acc_we_i (acc_we),
        .acc_idx_i (acc_idx), .acc_wdata_i (acc_wdata),
        .tcfg_o (tcfg), .tval_o (tval), .ticlr_o (ticlr), .timer_int_o (timer_int)
    );

    csr_read_result u_result (
        .clk (clk), .rst (rst),
        .acc_go_i (acc_go), .acc_idx_i (acc_idx),
        .crmd_i (crmd), .prmd_i (prmd), .ecfg_i (ecfg), .estat_i (estat),
        .era_i (era_o), .badv_i (badv), .eentry_i (eentry_o),
        .save0_i (save0), .save1_i (save1), .save2_i (save2), .save3_i (save3),
        .tid_i (tid), .tcfg_i (tcfg), .tval_i (tval), .ticlr_i (ticlr),
        .rdata_o (rdata_o)
    );

endmodule

// File: src/csr_read_result.sv
`timescale 1ns/100ps

module csr_read_result (
    input  logic              clk,
    input  logic              rst,
    input  logic              acc_go_i,
    input  csr_pkg::csr_idx_e acc_idx_i,
    input  logic [31:0]       crmd_i,
    input  logic [31:0]       prmd_i,
    input  logic [31:0]       ecfg_i,
    input  logic [31:0]       estat_i,
    input  logic [31:0]       era_i,
    input  logic [31:0]       badv_i,
    input  logic [31:0]       eentry_i,
    input  logic [31:0]       save0_i,
    input  logic [31:0]       save1_i,
    input  logic [31:0]       save2_i,
    input  logic [31:0]       save3_i,
    input  logic [31:0]       tid_i,
    input  logic [31:0]       tcfg_i,
    input  logic [31:0]       tval_i,
    input  logic [31:0]       ticlr_i,
    output logic [31:0]       rdata_o
);
    import csr_pkg::*;

    logic [31:0] sel;

    always_comb begin
        case (acc_idx_i)
            IDX_CRMD:   sel = crmd_i;
            IDX_PRMD:   sel = prmd_i;
            IDX_ECFG:   sel = ecfg_i;
            IDX_ESTAT:  sel = estat_i;
            IDX_ERA:    sel = era_i;
            IDX_BADV:   sel = badv_i;
            IDX_EENTRY: sel = eentry_i;
            IDX_SAVE0:  sel = save0_i;
            IDX_SAVE1:  sel = save1_i;
            IDX_SAVE2:  sel = save2_i;
            IDX_SAVE3:  sel = save3_i;
            IDX_TID:    sel = tid_i;
            IDX_TCFG:   sel = tcfg_i;
            IDX_TVAL:   sel = tval_i;
            IDX_TICLR:  sel = ticlr_i;
            default:    sel = '0;
        endcase
    end

    // Sampled on the write edge, so this is the old value
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_o <= '0;
        end else if (acc_go_i) begin
            rdata_o <= sel;
        end
    end

endmodule

// File: src/csr_timer.sv
`timescale 1ns/100ps

module csr_timer (
    input  logic              clk,
    input  logic              rst,
    input  logic              acc_go_i,
    input  logic              acc_we_i,
    input  csr_pkg::csr_idx_e acc_idx_i,
    input  logic [31:0]       acc_wdata_i,
    output logic [31:0]       tcfg_o,
    output logic [31:0]       tval_o,
    output logic [31:0]       ticlr_o,
    output logic              timer_int_o
);
    import csr_pkg::*;

    logic        tcfg_wr;
    logic        ticlr_wr;
    logic [31:0] reload;

    assign tcfg_wr  = acc_go_i && acc_we_i && acc_idx_i == IDX_TCFG;
    assign ticlr_wr = acc_go_i && acc_we_i && acc_idx_i == IDX_TICLR;
    assign reload   = {tcfg_o[31:2], 2'b00};
    assign ticlr_o  = '0; // Clear is write-only

    // Bit 0 enable, bit 1 periodic, 31:2 InitVal
    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_o <= '0;
            tval_o <= '0;
        end else if (tcfg_wr) begin
            tcfg_o <= acc_wdata_i;
            tval_o <= {acc_wdata_i[31:2], 2'b00}; // Start a new count
        end else if (tcfg_o[0]) begin
            if (tval_o != '0) begin
                tval_o <= tval_o - 32'd1;
            end else if (tcfg_o[1]) begin
                tval_o <= reload;
            end
        end
    end

    // Sticky until TICLR bit 0 is written
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_int_o <= 1'b0;
        end else if (!tcfg_wr && tcfg_o[0] && tval_o == 32'd1) begin
            timer_int_o <= 1'b1;
        end else if (ticlr_wr && acc_wdata_i[0]) begin
            timer_int_o <= 1'b0;
        end
    end

endmodule

// File: src/csr_state_regs.sv
`timescale 1ns/100ps

module csr_state_regs #(
    parameter logic [31:0] TID_RESET = 32'h0000_0000
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            acc_go_i,
    input  logic                            acc_we_i,
    input  csr_pkg::csr_idx_e               acc_idx_i,
    input  logic [31:0]                     acc_wdata_i,
    input  logic                            exc_valid_i,
    input  logic [csr_pkg::ECODE_W-1:0]     exc_ecode_i,
    input  logic [csr_pkg::ESUBCODE_W-1:0]  exc_esubcode_i,
    input  logic [31:0]                     exc_pc_i,
    input  logic [31:0]                     exc_addr_i,
    input  logic                            ertn_i,
    input  logic [csr_pkg::HWI_W-1:0]       hwi_i,
    input  logic                            ipi_i,
    input  logic                            timer_int_i,
    output logic [31:0]                     crmd_o,
    output logic [31:0]                     prmd_o,
    output logic [31:0]                     ecfg_o,
    output logic [31:0]                     estat_o,
    output logic [31:0]                     era_o,
    output logic [31:0]                     badv_o,
    output logic [31:0]                     eentry_o,
    output logic [31:0]                     save0_o,
    output logic [31:0]                     save1_o,
    output logic [31:0]                     save2_o,
    output logic [31:0]                     save3_o,
    output logic [31:0]                     tid_o,
    output logic [1:0]                      plv_o,
    output logic                            ie_o,
    output logic                            int_pending_o
);
    import csr_pkg::*;

    localparam csr_idx_e SAVE_IDX [4] = '{IDX_SAVE0, IDX_SAVE1, IDX_SAVE2, IDX_SAVE3};

    logic        wr;
    logic [31:0] save_q [4];

    assign wr = acc_go_i && acc_we_i;

    assign plv_o         = crmd_o[1:0];
    assign ie_o          = crmd_o[2];
    assign int_pending_o = ie_o && |(estat_o[12:0] & ecfg_o[12:0]);

    // Exception beats ertn, ertn beats the access write
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_o <= CRMD_RESET;
        end else if (exc_valid_i) begin
            crmd_o[2:0] <= 3'b000; // PLV0, IE off
        end else if (ertn_i) begin
            crmd_o[2:0] <= prmd_o[2:0];
        end else if (wr && acc_idx_i == IDX_CRMD) begin
            crmd_o <= acc_wdata_i & CRMD_WMASK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_o <= '0;
        end else if (exc_valid_i) begin
            prmd_o[2:0] <= crmd_o[2:0]; // Saved PLV/IE
        end else if (wr && acc_idx_i == IDX_PRMD) begin
            prmd_o <= acc_wdata_i & PRMD_WMASK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat_o <= '0;
        end else begin
            estat_o[9:2] <= hwi_i;
            estat_o[11]  <= timer_int_i;
            estat_o[12]  <= ipi_i;
            if (exc_valid_i) begin
                estat_o[21:16] <= exc_ecode_i;
                estat_o[30:22] <= exc_esubcode_i;
            end else if (wr && acc_idx_i == IDX_ESTAT) begin
                estat_o[1:0] <= acc_wdata_i[1:0] & ESTAT_WMASK[1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era_o  <= '0;
            badv_o <= '0;
        end else if (exc_valid_i) begin
            era_o <= exc_pc_i;
            if (exc_ecode_i == ECODE_ALE) begin
                badv_o <= exc_addr_i;
            end else if (exc_ecode_i == ECODE_ADE) begin
                badv_o <= exc_pc_i; // Fetch address fault
            end
        end else if (wr && acc_idx_i == IDX_ERA) begin
            era_o <= acc_wdata_i;
        end else if (wr && acc_idx_i == IDX_BADV) begin
            badv_o <= acc_wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg_o   <= '0;
            eentry_o <= '0;
            tid_o    <= TID_RESET;
        end else if (wr) begin
            case (acc_idx_i)
                IDX_ECFG:   ecfg_o   <= acc_wdata_i & ECFG_WMASK;
                IDX_EENTRY: eentry_o <= acc_wdata_i & EENTRY_WMASK;
                IDX_TID:    tid_o    <= acc_wdata_i;
                default:    ;
            endcase
        end
    end

    for (genvar k = 0; k < 4; k++) begin : g_save
        always_ff @(posedge clk) begin
            if (rst) begin
                save_q[k] <= '0;
            end else if (wr && acc_idx_i == SAVE_IDX[k]) begin
                save_q[k] <= acc_wdata_i;
            end
        end
    end

    assign save0_o = save_q[0];
    assign save1_o = save_q[1];
    assign save2_o = save_q[2];
    assign save3_o = save_q[3];

endmodule

// File: src/csr_access_decode.sv
`timescale 1ns/100ps

module csr_access_decode (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_i,
    input  logic               we_i,
    input  csr_pkg::csr_addr_t addr_i,
    input  logic [31:0]        wdata_i,
    output logic               ack_o,
    output logic               acc_go_o,
    output logic               acc_we_o,
    output csr_pkg::csr_idx_e  acc_idx_o,
    output logic [31:0]        acc_wdata_o
);
    import csr_pkg::*;

    csr_idx_e idx;
    logic     accept;

    // New request only while idle, not during the strobe cycle
    assign accept = req_i && !ack_o && !acc_go_o;

    always_comb begin
        case (addr_i)
            CSR_CRMD:   idx = IDX_CRMD;
            CSR_PRMD:   idx = IDX_PRMD;
            CSR_ECFG:   idx = IDX_ECFG;
            CSR_ESTAT:  idx = IDX_ESTAT;
            CSR_ERA:    idx = IDX_ERA;
            CSR_BADV:   idx = IDX_BADV;
            CSR_EENTRY: idx = IDX_EENTRY;
            CSR_SAVE0:  idx = IDX_SAVE0;
            CSR_SAVE1:  idx = IDX_SAVE1;
            CSR_SAVE2:  idx = IDX_SAVE2;
            CSR_SAVE3:  idx = IDX_SAVE3;
            CSR_TID:    idx = IDX_TID;
            CSR_TCFG:   idx = IDX_TCFG;
            CSR_TVAL:   idx = IDX_TVAL;
            CSR_TICLR:  idx = IDX_TICLR;
            default:    idx = IDX_NONE; // Reads zero, writes ignored
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_go_o <= 1'b0;
            ack_o    <= 1'b0;
        end else begin
            acc_go_o <= accept;
            if (acc_go_o) begin
                ack_o <= 1'b1; // Same edge as write and result
            end else if (!req_i) begin
                ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acc_we_o    <= we_i;
            acc_idx_o   <= idx;
            acc_wdata_o <= wdata_i;
        end
    end

endmodule

// File: src/csr_pkg.sv
package csr_pkg;

    typedef logic [13:0] csr_addr_t;

    // Architectural CSR numbers
    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_BADV   = 14'h007;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_SAVE1  = 14'h031;
    localparam csr_addr_t CSR_SAVE2  = 14'h032;
    localparam csr_addr_t CSR_SAVE3  = 14'h033;
    localparam csr_addr_t CSR_TID    = 14'h040;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;

    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int HWI_W      = 8;

    localparam logic [ECODE_W-1:0] ECODE_ADE = 6'h08;
    localparam logic [ECODE_W-1:0] ECODE_ALE = 6'h09;

    localparam logic [31:0] CRMD_WMASK   = 32'h0000_01ff;
    localparam logic [31:0] PRMD_WMASK   = 32'h0000_0007;
    localparam logic [31:0] ECFG_WMASK   = 32'h0000_1bff; // Bit 10 reserved
    localparam logic [31:0] ESTAT_WMASK  = 32'h0000_0003; // SW interrupts only
    localparam logic [31:0] EENTRY_WMASK = 32'hffff_ffc0;

    localparam logic [31:0] CRMD_RESET = 32'h0000_0008; // DA=1, PLV0, IE off

    typedef enum logic [4:0] {
        IDX_NONE,
        IDX_CRMD,
        IDX_PRMD,
        IDX_ECFG,
        IDX_ESTAT,
        IDX_ERA,
        IDX_BADV,
        IDX_EENTRY,
        IDX_SAVE0,
        IDX_SAVE1,
        IDX_SAVE2,
        IDX_SAVE3,
        IDX_TID,
        IDX_TCFG,
        IDX_TVAL,
        IDX_TICLR
    } csr_idx_e;

endpackage
